//--- flist.f
src/dmvm_params_pkg.sv
src/dmvm_ctrl_pkg.sv
src/coef_fifo_if.sv
src/dmvm_ctrl.sv
src/node_elem_counter.sv
src/wh_bram.sv
src/dmvm_mac.sv
src/coef_fifo.sv
src/dmvm_top.sv
verif/dmvm_assert.sv
verif/dmvm_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dmvm_tb -f flist.f -o dmvm_sim

out=$(./obj_dir/dmvm_sim +verilator+error+limit+1000 || true)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

//--- src/coef_fifo.sv
`timescale 1ns/1ps

module coef_fifo (
  input  logic     clk,
  input  logic     reset_i,
  coef_fifo_if.fifo fifo
);
  import dmvm_params_pkg::*;

  logic [COEF_WIDTH-1:0]  mem [FIFO_DEPTH];
  logic [FIFO_ADDR_W-1:0] wr_ptr_q;
  logic [FIFO_ADDR_W-1:0] rd_ptr_q;
  logic [FIFO_ADDR_W:0]   count_q;
  logic                   push;
  logic                   pop;

  assign push = fifo.wr_vld && !fifo.full;
  assign pop  = fifo.rd_vld && !fifo.empty;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= fifo.din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;      // wraps at the power of two depth.
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign fifo.dout  = mem[rd_ptr_q];      // fall-through head.
  assign fifo.full  = (count_q == (FIFO_ADDR_W+1)'(FIFO_DEPTH));
  assign fifo.empty = (count_q == '0);

endmodule

//--- src/coef_fifo_if.sv
`timescale 1ns/1ps

interface coef_fifo_if;
  import dmvm_params_pkg::*;

  logic [COEF_WIDTH-1:0] din;
  logic                  wr_vld;
  logic                  full;
  logic [COEF_WIDTH-1:0] dout;      // head entry while not empty.
  logic                  rd_vld;
  logic                  empty;

  modport wr (
    output din, wr_vld,
    input  full
  );

  modport fifo (
    input  din, wr_vld, rd_vld,
    output full, dout, empty
  );

  modport rd (
    output rd_vld,
    input  dout, empty
  );

endinterface

//--- src/dmvm_ctrl.sv
`timescale 1ns/1ps

module dmvm_ctrl (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    dmvm_valid_i,
  input  logic                    fifo_full_i,
  input  logic                    elem_last_i,
  input  logic                    node_last_i,
  output logic                    cnt_clr_o,
  output logic                    elem_inc_o,
  output logic                    node_inc_o,
  output dmvm_ctrl_pkg::mac_op_e  mac_op_o,
  output logic                    coef_wr_o,
  output logic                    dmvm_ready_o
);
  import dmvm_ctrl_pkg::*;

  dmvm_state_e state_q;
  dmvm_state_e state_nxt;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  always_comb begin
    state_nxt  = state_q;
    cnt_clr_o  = 1'b0;
    elem_inc_o = 1'b0;
    node_inc_o = 1'b0;
    mac_op_o   = OP_HOLD;
    coef_wr_o  = 1'b0;
    case (state_q)
      S_IDLE, S_DONE: begin
        if (dmvm_valid_i) begin
          cnt_clr_o = 1'b1;                  // latches the node count.
          state_nxt = S_FETCH;
        end
      end
      S_FETCH: begin
        mac_op_o  = OP_CLR;
        state_nxt = S_ACC;
      end
      S_ACC: begin
        mac_op_o   = OP_ACC;
        elem_inc_o = 1'b1;
        if (elem_last_i) begin
          state_nxt = S_WRITE;
        end
      end
      S_WRITE: begin
        if (!fifo_full_i) begin              // otherwise stall with everything held.
          coef_wr_o  = 1'b1;
          node_inc_o = 1'b1;
          state_nxt  = node_last_i ? S_DONE : S_FETCH;
        end
      end
      default: state_nxt = S_IDLE;
    endcase
  end

  assign dmvm_ready_o = (state_q == S_DONE);

endmodule

//--- src/dmvm_ctrl_pkg.sv
package dmvm_ctrl_pkg;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,                        // wh row address presented.
    S_ACC,                          // one mac per element.
    S_WRITE,                        // push, or wait on full.
    S_DONE
  } dmvm_state_e;

  typedef enum logic [1:0] {
    OP_HOLD,
    OP_CLR,
    OP_ACC
  } mac_op_e;

endpackage

//--- src/dmvm_mac.sv
`timescale 1ns/1ps

module dmvm_mac (
  input  logic                                 clk,
  input  logic                                 reset_i,
  input  logic [dmvm_params_pkg::DATA_WIDTH-1:0] a_din_i,
  input  logic                                 a_ena_i,
  input  logic [dmvm_params_pkg::A_ADDR_W-1:0] a_addra_i,
  input  logic [dmvm_params_pkg::WH_WIDTH-1:0] wh_row_i,
  input  logic [dmvm_params_pkg::A_ADDR_W-1:0] elem_idx_i,
  input  dmvm_ctrl_pkg::mac_op_e               mac_op_i,
  input  logic                                 coef_wr_i,
  coef_fifo_if.wr                              fifo
);
  import dmvm_params_pkg::*;
  import dmvm_ctrl_pkg::*;

  logic signed [DATA_WIDTH-1:0]   a_q [A_DEPTH];
  logic signed [DATA_WIDTH-1:0]   a_sel;
  logic signed [DATA_WIDTH-1:0]   wh_sel;
  logic signed [2*DATA_WIDTH-1:0] prod;
  logic signed [COEF_WIDTH-1:0]   acc_q;

  always_ff @(posedge clk) begin
    if (a_ena_i) begin
      a_q[a_addra_i] <= a_din_i;
    end
  end

  assign a_sel  = a_q[elem_idx_i];
  assign wh_sel = wh_row_i[elem_idx_i*DATA_WIDTH +: DATA_WIDTH];
  assign prod   = a_sel * wh_sel;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      acc_q <= '0;
    end else begin
      case (mac_op_i)
        OP_CLR:  acc_q <= '0;
        OP_ACC:  acc_q <= acc_q + COEF_WIDTH'(prod);   // sign extended product.
        default: acc_q <= acc_q;
      endcase
    end
  end

  // leaky relu; the arithmetic shift rounds toward minus infinity.
  assign fifo.din    = acc_q[COEF_WIDTH-1] ? (acc_q >>> LRELU_SHIFT) : acc_q;
  assign fifo.wr_vld = coef_wr_i;

endmodule

//--- src/dmvm_params_pkg.sv
package dmvm_params_pkg;

  // element and row geometry
  localparam int DATA_WIDTH  = 8;
  localparam int A_DEPTH     = 4;
  localparam int A_ADDR_W    = $clog2(A_DEPTH);
  localparam int WH_WIDTH    = A_DEPTH * DATA_WIDTH;   // element 0 in the low bits.

  // node storage
  localparam int MAX_NODES   = 16;
  localparam int NODE_ADDR_W = $clog2(MAX_NODES);
  localparam int NUM_NODE_W  = NODE_ADDR_W + 1;        // counts 1 to MAX_NODES.

  // accumulator and activation
  localparam int COEF_WIDTH  = 20;
  localparam int LRELU_SHIFT = 3;                      // negative slope of 1/8.

  // coefficient queue
  localparam int FIFO_DEPTH  = 8;
  localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

endpackage

//--- src/dmvm_top.sv
`timescale 1ns/1ps

module dmvm_top (
  input  logic                                    clk,
  input  logic                                    reset_i,
  input  logic [dmvm_params_pkg::DATA_WIDTH-1:0]  a_din_i,
  input  logic                                    a_ena_i,
  input  logic [dmvm_params_pkg::A_ADDR_W-1:0]    a_addra_i,
  input  logic [dmvm_params_pkg::WH_WIDTH-1:0]    wh_din_i,
  input  logic                                    wh_ena_i,
  input  logic [dmvm_params_pkg::NODE_ADDR_W-1:0] wh_addra_i,
  input  logic [dmvm_params_pkg::NUM_NODE_W-1:0]  num_node_i,
  input  logic                                    dmvm_valid_i,
  output logic                                    dmvm_ready_o,
  output logic [dmvm_params_pkg::COEF_WIDTH-1:0]  coef_dout_o,
  input  logic                                    coef_rd_i,
  output logic                                    coef_empty_o
);
  import dmvm_params_pkg::*;
  import dmvm_ctrl_pkg::*;

  logic                   cnt_clr;
  logic                   elem_inc;
  logic                   node_inc;
  logic                   elem_last;
  logic                   node_last;
  logic                   coef_wr;
  mac_op_e                mac_op;
  logic [NODE_ADDR_W-1:0] node_idx;
  logic [A_ADDR_W-1:0]    elem_idx;
  logic [WH_WIDTH-1:0]    wh_row;

  coef_fifo_if fifo_if ();

  // outside drain side.
  assign fifo_if.rd_vld = coef_rd_i;
  assign coef_dout_o    = fifo_if.dout;
  assign coef_empty_o   = fifo_if.empty;

  dmvm_ctrl u_dmvm_ctrl (
    .clk          (clk          ),
    .reset_i      (reset_i      ),
    .dmvm_valid_i (dmvm_valid_i ),
    .fifo_full_i  (fifo_if.full ),
    .elem_last_i  (elem_last    ),
    .node_last_i  (node_last    ),
    .cnt_clr_o    (cnt_clr      ),
    .elem_inc_o   (elem_inc     ),
    .node_inc_o   (node_inc     ),
    .mac_op_o     (mac_op       ),
    .coef_wr_o    (coef_wr      ),
    .dmvm_ready_o (dmvm_ready_o )
  );

  node_elem_counter u_node_elem_counter (
    .clk          (clk          ),
    .reset_i      (reset_i      ),
    .num_node_i   (num_node_i   ),
    .clr_i        (cnt_clr      ),
    .elem_inc_i   (elem_inc     ),
    .node_inc_i   (node_inc     ),
    .node_idx_o   (node_idx     ),
    .elem_idx_o   (elem_idx     ),
    .elem_last_o  (elem_last    ),
    .node_last_o  (node_last    )
  );

  wh_bram u_wh_bram (
    .clk          (clk          ),
    .wh_ena_i     (wh_ena_i     ),
    .wh_addra_i   (wh_addra_i   ),
    .wh_din_i     (wh_din_i     ),
    .wh_addrb_i   (node_idx     ),
    .wh_doutb_o   (wh_row       )
  );

  dmvm_mac u_dmvm_mac (
    .clk          (clk          ),
    .reset_i      (reset_i      ),
    .a_din_i      (a_din_i      ),
    .a_ena_i      (a_ena_i      ),
    .a_addra_i    (a_addra_i    ),
    .wh_row_i     (wh_row       ),
    .elem_idx_i   (elem_idx     ),
    .mac_op_i     (mac_op       ),
    .coef_wr_i    (coef_wr      ),
    .fifo         (fifo_if.wr   )
  );

  coef_fifo u_coef_fifo (
    .clk          (clk          ),
    .reset_i      (reset_i      ),
    .fifo         (fifo_if.fifo )
  );

endmodule

//--- src/node_elem_counter.sv
`timescale 1ns/1ps

module node_elem_counter (
  input  logic                                   clk,
  input  logic                                   reset_i,
  input  logic [dmvm_params_pkg::NUM_NODE_W-1:0] num_node_i,
  input  logic                                   clr_i,
  input  logic                                   elem_inc_i,
  input  logic                                   node_inc_i,
  output logic [dmvm_params_pkg::NODE_ADDR_W-1:0] node_idx_o,
  output logic [dmvm_params_pkg::A_ADDR_W-1:0]   elem_idx_o,
  output logic                                   elem_last_o,
  output logic                                   node_last_o
);
  import dmvm_params_pkg::*;

  logic [NUM_NODE_W-1:0] num_node_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      num_node_q <= '0;
      node_idx_o <= '0;
      elem_idx_o <= '0;
    end else if (clr_i) begin
      num_node_q <= (num_node_i == '0) ? NUM_NODE_W'(1) : num_node_i;  // zero runs one node.
      node_idx_o <= '0;
      elem_idx_o <= '0;
    end else begin
      if (elem_inc_i) begin
        elem_idx_o <= elem_last_o ? '0 : elem_idx_o + 1'b1;
      end
      if (node_inc_i) begin
        node_idx_o <= node_idx_o + 1'b1;
      end
    end
  end

  assign elem_last_o = (elem_idx_o == A_ADDR_W'(A_DEPTH - 1));
  assign node_last_o = ({1'b0, node_idx_o} + 1'b1 == num_node_q);

endmodule

//--- src/wh_bram.sv
`timescale 1ns/1ps

module wh_bram (
  input  logic                                    clk,
  input  logic                                    wh_ena_i,
  input  logic [dmvm_params_pkg::NODE_ADDR_W-1:0] wh_addra_i,
  input  logic [dmvm_params_pkg::WH_WIDTH-1:0]    wh_din_i,
  input  logic [dmvm_params_pkg::NODE_ADDR_W-1:0] wh_addrb_i,
  output logic [dmvm_params_pkg::WH_WIDTH-1:0]    wh_doutb_o
);
  import dmvm_params_pkg::*;

  logic [WH_WIDTH-1:0] mem [MAX_NODES];

  // write port.
  always_ff @(posedge clk) begin
    if (wh_ena_i) begin
      mem[wh_addra_i] <= wh_din_i;
    end
  end

  // registered read, one cycle behind the address.
  always_ff @(posedge clk) begin
    wh_doutb_o <= mem[wh_addrb_i];
  end

endmodule

//--- verif/dmvm_assert.sv
`timescale 1ns/1ps

module dmvm_assert (
  input logic clk,
  input logic reset_i,
  input logic valid_i,
  input logic ready_i,
  input logic wr_vld_i,
  input logic full_i,
  input logic empty_i
);

  int   fail_cnt = 0;
  logic started_q;                          // set by the first start after reset.

  always_ff @(posedge clk) begin
    if (reset_i) begin
      started_q <= 1'b0;
    end else if (valid_i) begin
      started_q <= 1'b1;
    end
  end

  no_push_when_full: assert property (@(posedge clk) disable iff (reset_i)
    !(wr_vld_i && full_i))
    else begin
      fail_cnt++;
      $error("coefficient fifo written while full");
    end

  ready_after_start: assert property (@(posedge clk) disable iff (reset_i)
    $rose(ready_i) |-> started_q)
    else begin
      fail_cnt++;
      $error("ready rose without a start");
    end

  full_empty_apart: assert property (@(posedge clk) disable iff (reset_i)
    !(empty_i && (full_i || $past(full_i))))   // one pop never empties a full fifo.
    else begin
      fail_cnt++;
      $error("fifo full and empty together or one cycle apart");
    end

endmodule

bind dmvm_top dmvm_assert u_dmvm_assert (
  .clk      (clk          ),
  .reset_i  (reset_i      ),
  .valid_i  (dmvm_valid_i ),
  .ready_i  (dmvm_ready_o ),
  .wr_vld_i (coef_wr      ),
  .full_i   (fifo_if.full ),
  .empty_i  (coef_empty_o )
);

//--- verif/dmvm_cases.txt
# a <four signed a elements> | w <first node> <count> <hex rows, element 0 in low byte>
# x <count> <expected coefficients in node order> | run <node count> <drain 0 now 1 held 2 random>
a 1 2 3 4
w 0 4 01010101 01000002 00000500 0a0a0a0a
x 4 10 6 10 100
run 4 0
# negative sums, row 2 reloaded
a -1 -2 -3 -4
w 2 1 00000a00
x 4 -2 -1 -3 -13
run 4 0
x 4 -2 -1 -3 -13
run 4 2
# twelve nodes against an eight deep fifo
a 1 1 1 1
w 4 8 00000001 00000002 000000ff 7f7f7f7f 80808080 00000010 01020304 fffffff0
x 12 4 3 10 40 1 2 -1 508 -64 16 10 -3
run 12 1
# zero node count runs one node
a 3 0 0 0
x 1 3
run 0 1

//--- verif/dmvm_tb.sv
`timescale 1ns/1ps

module dmvm_tb;
  import dmvm_params_pkg::*;

  logic                   clk;
  logic                   reset_i;
  logic [DATA_WIDTH-1:0]  a_din_i;
  logic                   a_ena_i;
  logic [A_ADDR_W-1:0]    a_addra_i;
  logic [WH_WIDTH-1:0]    wh_din_i;
  logic                   wh_ena_i;
  logic [NODE_ADDR_W-1:0] wh_addra_i;
  logic [NUM_NODE_W-1:0]  num_node_i;
  logic                   dmvm_valid_i;
  logic                   dmvm_ready_o;
  logic [COEF_WIDTH-1:0]  coef_dout_o;
  logic                   coef_rd_i;
  logic                   coef_empty_o;

  logic signed [DATA_WIDTH-1:0] a_m [A_DEPTH];    // mirror of the loaded a vector.
  logic [WH_WIDTH-1:0]          wh_m [MAX_NODES];
  int                           exp_q [$];        // expected coefficients of the next job.
  int                           errors = 0;
  int                           checks = 0;
  int                           cycle_cnt = 0;
  int                           cycle_limit = 200;
  bit                           started = 1'b0;

  dmvm_top dmvm_top_i (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run was still busy after %0d cycles", cycle_cnt);
      $display("tests failed");
      $finish;
    end
  end

  task automatic compare(input logic signed [31:0] got, input logic signed [31:0] want,
                         input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR @%0t %s: got %0d, expected %0d", $time, what, got, want);
    end
  endtask

  function automatic int coef_model(input int node);
    logic signed [DATA_WIDTH-1:0] e;
    int                           sum;
    sum = 0;
    for (int k = 0; k < A_DEPTH; k++) begin
      e = wh_m[node][k*DATA_WIDTH +: DATA_WIDTH];
      sum += int'(a_m[k]) * int'(e);
    end
    if (sum < 0) begin
      sum = -((-sum + (1 << LRELU_SHIFT) - 1) / (1 << LRELU_SHIFT));  // floor of sum / 8.
    end
    return sum;
  endfunction

  task automatic load_a(input int idx, input int val);
    a_addra_i = A_ADDR_W'(idx);
    a_din_i   = DATA_WIDTH'(val);
    a_ena_i   = 1'b1;
    a_m[idx]  = DATA_WIDTH'(val);
    @(posedge clk);
    #1;
    a_ena_i = 1'b0;
  endtask

  task automatic load_wh(input int addr, input logic [WH_WIDTH-1:0] row);
    wh_addra_i = NODE_ADDR_W'(addr);
    wh_din_i   = row;
    wh_ena_i   = 1'b1;
    wh_m[addr] = row;
    @(posedge clk);
    #1;
    wh_ena_i = 1'b0;
  endtask

  task automatic run_job(input int nodes, input int mode);
    int n_eff;
    int got_n;
    int wait_n;
    n_eff = (nodes == 0) ? 1 : nodes;
    cycle_limit += n_eff * (A_DEPTH + 2) + 200;
    if (exp_q.size() != n_eff) begin
      errors++;
      $display("case file gives %0d expected values for a job of %0d nodes",
               exp_q.size(), n_eff);
    end
    compare(int'(dmvm_ready_o), int'(started), "ready before start");
    num_node_i   = NUM_NODE_W'(nodes);
    dmvm_valid_i = 1'b1;
    @(posedge clk);
    #1;
    dmvm_valid_i = 1'b0;
    started      = 1'b1;
    compare(int'(dmvm_ready_o), 0, "ready after start");
    if (mode == 1) begin                    // hold the drain; long jobs stall on full.
      wait_n = 0;
      while (!dmvm_ready_o && wait_n < n_eff * (A_DEPTH + 2) + 8) begin
        @(posedge clk);
        #1;
        wait_n++;
      end
      compare(int'(dmvm_ready_o), int'(n_eff <= FIFO_DEPTH), "ready after held drain");
    end
    got_n = 0;
    while (got_n < n_eff) begin
      coef_rd_i = 1'b0;
      if (got_n + FIFO_DEPTH < n_eff) begin   // the last node cannot be in the fifo yet.
        compare(int'(dmvm_ready_o), 0, "ready while nodes are pending");
      end
      if (!coef_empty_o && (mode != 2 || $urandom % 3 == 0)) begin
        compare(int'($signed(coef_dout_o)), coef_model(got_n),
                $sformatf("node %0d against the rule", got_n));
        if (got_n < exp_q.size()) begin
          compare(int'($signed(coef_dout_o)), exp_q[got_n],
                  $sformatf("node %0d against the file", got_n));
        end
        coef_rd_i = 1'b1;                   // pops on the next edge.
        got_n++;
      end
      @(posedge clk);
      #1;
    end
    coef_rd_i = 1'b0;
    while (!dmvm_ready_o) begin
      @(posedge clk);
      #1;
    end
    compare(int'(coef_empty_o), 1, "empty after drain");
    exp_q.delete();
  endtask

  initial begin
    int                  fd;
    int                  rc;
    int                  v;
    int                  base;
    int                  cnt;
    int                  nodes;
    int                  mode;
    int                  seed;
    int                  afail;
    logic [63:0]         key;
    logic [8*256-1:0]    rest;
    logic [WH_WIDTH-1:0] row;
    seed         = $urandom(32'he8c69746);
    clk          = 1'b0;
    reset_i      = 1'b1;
    a_din_i      = '0;
    a_ena_i      = 1'b0;
    a_addra_i    = '0;
    wh_din_i     = '0;
    wh_ena_i     = 1'b0;
    wh_addra_i   = '0;
    num_node_i   = '0;
    dmvm_valid_i = 1'b0;
    coef_rd_i    = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset_i = 1'b0;
    compare(int'(dmvm_ready_o), 0, "ready after reset");
    compare(int'(coef_empty_o), 1, "empty after reset");
    fd = $fopen("verif/dmvm_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open verif/dmvm_cases.txt");
    end else begin
      while ($fscanf(fd, "%s", key) == 1) begin
        if (key == "#") begin
          rc = $fgets(rest, fd);
        end else if (key == "a") begin
          for (int i = 0; i < A_DEPTH; i++) begin
            rc = $fscanf(fd, "%d", v);
            load_a(i, v);
          end
        end else if (key == "w") begin
          rc = $fscanf(fd, "%d %d", base, cnt);
          for (int i = 0; i < cnt; i++) begin
            rc = $fscanf(fd, "%h", row);
            load_wh(base + i, row);
          end
        end else if (key == "x") begin
          rc = $fscanf(fd, "%d", cnt);
          for (int i = 0; i < cnt; i++) begin
            rc = $fscanf(fd, "%d", v);
            exp_q.push_back(v);
          end
        end else if (key == "run") begin
          rc = $fscanf(fd, "%d %d", nodes, mode);
          run_job(nodes, mode);
        end else begin
          errors++;
          $display("unknown keyword in the case file");
        end
      end
      $fclose(fd);
    end
    afail = dmvm_top_i.u_dmvm_assert.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afail);
    if (errors == 0 && afail == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
